// ==== vlog.f ====
+incdir+bench
design/riscv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/id_field_decode.sv
design/id_ctrl_gen.sv
design/id_operand_gen.sv
design/decode_unit.sv
bench/tb_decode_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_decode_unit -o tb_decode_unit
out=$(./obj_dir/tb_decode_unit)
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// ==== bench/tb_decode_ref.svh ====
// Reference decode model, xorshift generator and opcode pickers for the testbench
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// Expected DUT outputs for one set of inputs
typedef struct packed {
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  addr_t        pc;
  id_ctrl_t     ctrl;
  id_operands_t ops;
  logic         ready;
  logic         valid;
} expect_t;

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Set every bit from width upward when the sign is one
function automatic data_t sign_fill(input data_t raw, input int width, input logic sign);
  return sign ? (raw | (~32'd0 << width)) : raw;
endfunction

// Supported opcodes with the five funct3-decoded ones first
function automatic opcode_t opcode_at(input logic [31:0] idx);
  case (idx % 32'd9)
    32'd0:   return LOAD_OP;
    32'd1:   return STORE_OP;
    32'd2:   return IMM_OP;
    32'd3:   return REG_OP;
    32'd4:   return BRANCH_OP;
    32'd5:   return AUIPC_OP;
    32'd6:   return LUI_OP;
    32'd7:   return JALR_OP;
    default: return JAL_OP;
  endcase
endfunction

// RV64 W forms, SYSTEM or raw bits
function automatic opcode_t opcode_unsupported(input logic [31:0] r);
  case (r[1:0])
    2'd0:    return 7'b0011011;
    2'd1:    return 7'b0111011;
    2'd2:    return 7'b1110011;
    default: return r[8:2];  // may land on a supported code
  endcase
endfunction

// Expected outputs from the decode rules
function automatic expect_t decode_ref(input logic rstn, input logic exe_rdy, input addr_t pc,
                                       input instr_t ins, input data_t d1, input data_t d2,
                                       input logic dirty1, input logic dirty2);
  expect_t e;
  opcode_t op;
  funct3_t f3;
  data_t   imm;
  op   = ins[6:0];
  f3   = ins[14:12];
  e    = '0;
  e.pc = pc;
  // Reset and unsupported words decode to the idle codes
  e.ctrl.exe = EXE_ADD;
  e.ctrl.mem = MEM_IDLE;
  e.ctrl.gpr = GPR_IDLE;
  e.ctrl.pc  = PC_INC;
  if (!rstn) begin
    return e;
  end
  if (!(op inside {LOAD_OP, IMM_OP, AUIPC_OP, STORE_OP, REG_OP, LUI_OP, BRANCH_OP,
                   JALR_OP, JAL_OP})) begin
    e.ready = 1'b1;
    return e;
  end
  e.valid = !dirty1 && !dirty2;
  e.ready = e.valid && exe_rdy;
  // Index masking by format
  e.rs1 = (op inside {AUIPC_OP, LUI_OP, JAL_OP}) ? 5'd0 : ins[19:15];
  e.rs2 = (op inside {REG_OP, STORE_OP, BRANCH_OP}) ? ins[24:20] : 5'd0;
  e.rd  = (op inside {STORE_OP, BRANCH_OP}) ? 5'd0 : ins[11:7];
  case (op)
    STORE_OP:
      imm = sign_fill({20'b0, ins[31:25], ins[11:7]}, 12, ins[31]);
    BRANCH_OP:
      imm = sign_fill({19'b0, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13, ins[31]);
    AUIPC_OP, LUI_OP:
      imm = {ins[31:12], 12'b0};
    JAL_OP:
      imm = sign_fill({11'b0, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21, ins[31]);
    REG_OP:
      imm = '0;
    // I format where shift amounts stay unsigned
    default:
      imm = (op == IMM_OP && (f3 == 3'b001 || f3 == 3'b101)) ? {20'b0, ins[31:20]}
          : sign_fill({20'b0, ins[31:20]}, 12, ins[31]);
  endcase
  if (op == REG_OP || op == IMM_OP) begin
    case (f3)
      3'b000:  e.ctrl.exe = (op == REG_OP && ins[30]) ? EXE_SUB : EXE_ADD;
      3'b001:  e.ctrl.exe = EXE_SLL;
      3'b010:  e.ctrl.exe = EXE_SLT;
      3'b011:  e.ctrl.exe = EXE_SLTU;
      3'b100:  e.ctrl.exe = EXE_XOR;
      3'b101:  e.ctrl.exe = ins[30] ? EXE_SRA : EXE_SRL;
      3'b110:  e.ctrl.exe = EXE_OR;
      default: e.ctrl.exe = EXE_AND;
    endcase
  end else if (op == BRANCH_OP) begin
    case (f3)
      3'b000:  e.ctrl.exe = EXE_EQ;
      3'b001:  e.ctrl.exe = EXE_NE;
      3'b100:  e.ctrl.exe = EXE_SLT;
      3'b101:  e.ctrl.exe = EXE_GE;
      3'b110:  e.ctrl.exe = EXE_SLTU;
      3'b111:  e.ctrl.exe = EXE_GEU;
      default: e.ctrl.exe = EXE_ADD;
    endcase
  end
  if (op == LOAD_OP) begin
    case (f3)
      3'b000:  e.ctrl.mem = MEM_RB;
      3'b001:  e.ctrl.mem = MEM_RH;
      3'b100:  e.ctrl.mem = MEM_RBU;
      3'b101:  e.ctrl.mem = MEM_RHU;
      default: e.ctrl.mem = MEM_RW;
    endcase
  end else if (op == STORE_OP) begin
    e.ctrl.mem = (f3 == 3'b000) ? MEM_WB : (f3 == 3'b001) ? MEM_WH : MEM_WW;
  end
  case (op)
    LOAD_OP:             e.ctrl.gpr = GPR_MEM;
    JAL_OP, JALR_OP:     e.ctrl.gpr = GPR_PRGMC;
    STORE_OP, BRANCH_OP: e.ctrl.gpr = GPR_IDLE;
    default:             e.ctrl.gpr = GPR_ALU;
  endcase
  e.ctrl.pc = (op == JALR_OP) ? PC_SET : (op == JAL_OP) ? PC_ADD
            : (op == BRANCH_OP) ? PC_COND : PC_INC;
  // Operand table in op1, op2, op3 order
  case (op)
    STORE_OP:  e.ops = '{d1, imm, d2};
    REG_OP:    e.ops = '{d1, d2, 32'd0};
    AUIPC_OP:  e.ops = '{pc, imm, 32'd0};
    LUI_OP:    e.ops = '{32'd0, imm, 32'd0};
    BRANCH_OP: e.ops = '{d1, d2, imm};
    JALR_OP:   e.ops = '{d1, imm, pc};
    JAL_OP:    e.ops = '{32'd0, imm, pc};
    default:   e.ops = '{d1, imm, 32'd0};  // LOAD and IMM
  endcase
  return e;
endfunction

`endif

// ==== bench/tb_decode_unit.sv ====
// Decode stage testbench with clock, reset, random stimulus, compare process and timeout
`timescale 1ns/1ps

module tb_decode_unit;

  import riscv_isa_pkg::*;
  import core_ctrl_pkg::*;

  `include "tb_decode_ref.svh"

  localparam int NUM_TESTS = 5;
  // Close to twice the 1060 cycles that the five tests take
  localparam int TIMEOUT_CYCLES = 2000;

  logic         clk;
  logic         rstn;
  logic         exe_ready;
  addr_t        pc;
  instr_t       instr;
  data_t        rs1_data;
  data_t        rs2_data;
  logic         rs1_dirty;
  logic         rs2_dirty;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  addr_t        pc_out;
  id_ctrl_t     ctrl;
  id_operands_t operands;
  logic         ready;
  logic         valid;

  logic [31:0]  rng;
  logic         check_en;
  int           test_id;
  int           cycle_count;
  int           test_errs [1:NUM_TESTS];
  int           test_checks [1:NUM_TESTS];

  decode_unit u_dut (
    .rstn_i      (rstn),
    .exe_ready_i (exe_ready),
    .pc_i        (pc),
    .instr_i     (instr),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rs1_dirty_i (rs1_dirty),
    .rs2_dirty_i (rs2_dirty),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .pc_o        (pc_out),
    .ctrl_o      (ctrl),
    .operands_o  (operands),
    .ready_o     (ready),
    .valid_o     (valid)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_error(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    $display("Error: %s got 0x%h expected 0x%h in test %0d", name, got, want, test_id);
    test_errs[test_id]++;
  endtask

  task automatic check_outputs(input expect_t e);
    test_checks[test_id]++;
    if (rs1 !== e.rs1)
      report_error("rs1_o", 32'(rs1), 32'(e.rs1));
    if (rs2 !== e.rs2)
      report_error("rs2_o", 32'(rs2), 32'(e.rs2));
    if (rd !== e.rd)
      report_error("rd_o", 32'(rd), 32'(e.rd));
    if (pc_out !== e.pc)
      report_error("pc_o", pc_out, e.pc);
    if (ctrl.exe !== e.ctrl.exe)
      report_error("ctrl_o.exe", 32'(ctrl.exe), 32'(e.ctrl.exe));
    if (ctrl.mem !== e.ctrl.mem)
      report_error("ctrl_o.mem", 32'(ctrl.mem), 32'(e.ctrl.mem));
    if (ctrl.gpr !== e.ctrl.gpr)
      report_error("ctrl_o.gpr", 32'(ctrl.gpr), 32'(e.ctrl.gpr));
    if (ctrl.pc !== e.ctrl.pc)
      report_error("ctrl_o.pc", 32'(ctrl.pc), 32'(e.ctrl.pc));
    if (operands.op1 !== e.ops.op1)
      report_error("operands_o.op1", operands.op1, e.ops.op1);
    if (operands.op2 !== e.ops.op2)
      report_error("operands_o.op2", operands.op2, e.ops.op2);
    if (operands.op3 !== e.ops.op3)
      report_error("operands_o.op3", operands.op3, e.ops.op3);
    if (ready !== e.ready)
      report_error("ready_o", 32'(ready), 32'(e.ready));
    if (valid !== e.valid)
      report_error("valid_o", 32'(valid), 32'(e.valid));
  endtask

  // New random word and side inputs for one cycle
  task automatic drive_cycle(input int id, input int n);
    opcode_t op;
    rng = xorshift32(rng);
    case (id)
      3:       op = opcode_at(rng % 32'd5);
      // Walk all nine opcodes evenly
      4:       op = opcode_at(n);
      5:       op = rng[31] ? opcode_unsupported(rng) : opcode_at(rng);
      default: op = opcode_at(rng);
    endcase
    rng       = xorshift32(rng);
    instr     = {rng[31:7], op};
    rng       = xorshift32(rng);
    pc        = rng;
    rng       = xorshift32(rng);
    rs1_data  = rng;
    rng       = xorshift32(rng);
    rs2_data  = rng;
    rng       = xorshift32(rng);
    rs1_dirty = rng[0];
    rs2_dirty = rng[1];
    exe_ready = rng[2];
  endtask

  task automatic run_test(input int id, input string name, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      #1;
      drive_cycle(id, n);
      test_id  = id;
      check_en = 1'b1;
    end
    @(posedge clk);
    #1;
    check_en = 1'b0;
    $display("Test %0d %s: %0d checks, %0d errors, %s", id, name, test_checks[id],
             test_errs[id], (test_errs[id] == 0 && test_checks[id] > 0) ? "passed" : "failed");
  endtask

  // Sample just before the next rising edge
  initial begin : compare
    expect_t exp;
    forever begin
      @(posedge clk);
      #9;
      if (check_en) begin
        exp = decode_ref(rstn, exe_ready, pc, instr, rs1_data, rs2_data, rs1_dirty, rs2_dirty);
        check_outputs(exp);
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int failed;
    int total_errs;
    int total_checks;
    rstn         = 1'b0;
    exe_ready    = 1'b0;
    pc           = '0;
    instr        = '0;
    rs1_data     = '0;
    rs2_data     = '0;
    rs1_dirty    = 1'b0;
    rs2_dirty    = 1'b0;
    rng          = 32'd17;
    check_en     = 1'b0;
    test_id      = 1;
    failed       = 0;
    total_errs   = 0;
    total_checks = 0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      test_errs[t]   = 0;
      test_checks[t] = 0;
    end
    // Legal words while reset is held low
    run_test(1, "reset", 5);
    rstn = 1'b1;
    run_test(2, "register indices", 300);
    run_test(3, "control codes", 300);
    run_test(4, "operands and immediates", 300);
    run_test(5, "hazard, back-pressure and unsupported opcodes", 150);
    for (int t = 1; t <= NUM_TESTS; t++) begin
      total_errs   += test_errs[t];
      total_checks += test_checks[t];
      if (test_errs[t] != 0 || test_checks[t] == 0)
        failed++;
    end
    $display("Done: %0d tests, %0d failed, %0d checks, %0d errors", NUM_TESTS, failed,
             total_checks, total_errs);
    if (failed == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== design/decode_unit.sv ====
// Decode stage top level, field decode, control and operand generation
`timescale 1ns/1ps

module decode_unit (
  input  logic                        rstn_i,
  input  logic                        exe_ready_i,
  input  riscv_isa_pkg::addr_t        pc_i,
  input  riscv_isa_pkg::instr_t       instr_i,
  input  riscv_isa_pkg::data_t        rs1_data_i,
  input  riscv_isa_pkg::data_t        rs2_data_i,
  input  logic                        rs1_dirty_i,
  input  logic                        rs2_dirty_i,
  output riscv_isa_pkg::reg_idx_t     rs1_o,
  output riscv_isa_pkg::reg_idx_t     rs2_o,
  output riscv_isa_pkg::reg_idx_t     rd_o,
  output riscv_isa_pkg::addr_t        pc_o,
  output core_ctrl_pkg::id_ctrl_t     ctrl_o,
  output core_ctrl_pkg::id_operands_t operands_o,
  output logic                        ready_o,
  output logic                        valid_o
);

  import riscv_isa_pkg::*;

  // Masked fields shared by both back ends
  id_fields_t fields;

  id_field_decode u_field_decode (
    .rstn_i      (rstn_i),
    .instr_i     (instr_i),
    .exe_ready_i (exe_ready_i),
    .rs1_dirty_i (rs1_dirty_i),
    .rs2_dirty_i (rs2_dirty_i),
    .fields_o    (fields),
    .ready_o     (ready_o),
    .valid_o     (valid_o)
  );

  id_ctrl_gen u_ctrl_gen (
    .fields_i (fields),
    .ctrl_o   (ctrl_o)
  );

  id_operand_gen u_operand_gen (
    .fields_i   (fields),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .operands_o (operands_o)
  );

  // GPR read ports and writeback index
  assign rs1_o = fields.rs1;
  assign rs2_o = fields.rs2;
  assign rd_o  = fields.rd;
  // PC passes straight to execute
  assign pc_o  = pc_i;

endmodule

// ==== design/id_operand_gen.sv ====
// Operand word selection for op1, op2 and op3 per opcode
`timescale 1ns/1ps

module id_operand_gen (
  input  riscv_isa_pkg::id_fields_t   fields_i,
  input  riscv_isa_pkg::addr_t        pc_i,
  input  riscv_isa_pkg::data_t        rs1_data_i,
  input  riscv_isa_pkg::data_t        rs2_data_i,
  output core_ctrl_pkg::id_operands_t operands_o
);

  import riscv_isa_pkg::*;

  data_t op1;
  data_t op2;
  data_t op3;

  // Immediate arrives already expanded for its format
  always_comb begin : operand_select
    op1 = '0;
    op2 = '0;
    op3 = '0;
    case (fields_i.opcode)
      LOAD_OP, IMM_OP: begin
        op1 = rs1_data_i;
        op2 = fields_i.imm;
      end
      STORE_OP: begin
        // Address base plus offset, store data rides on op3
        op1 = rs1_data_i;
        op2 = fields_i.imm;
        op3 = rs2_data_i;
      end
      REG_OP: begin
        op1 = rs1_data_i;
        op2 = rs2_data_i;
      end
      AUIPC_OP: begin
        op1 = pc_i;
        op2 = fields_i.imm;
      end
      LUI_OP: begin
        // Zero plus upper immediate through the adder
        op2 = fields_i.imm;
      end
      BRANCH_OP: begin
        // Compare rs1 with rs2, target offset on op3
        op1 = rs1_data_i;
        op2 = rs2_data_i;
        op3 = fields_i.imm;
      end
      JALR_OP: begin
        op1 = rs1_data_i;
        op2 = fields_i.imm;
        // Link address base
        op3 = pc_i;
      end
      JAL_OP: begin
        op2 = fields_i.imm;
        op3 = pc_i;
      end
      default: begin
        // Unsupported or reset, all zero
        op1 = '0;
      end
    endcase
  end

  assign operands_o.op1 = op1;
  assign operands_o.op2 = op2;
  assign operands_o.op3 = op3;

endmodule

// ==== design/id_ctrl_gen.sv ====
// Execute, memory, writeback and PC control code generation from decoded fields
`timescale 1ns/1ps

module id_ctrl_gen (
  input  riscv_isa_pkg::id_fields_t fields_i,
  output core_ctrl_pkg::id_ctrl_t   ctrl_o
);

  import riscv_isa_pkg::*;
  import core_ctrl_pkg::*;

  exe_op_t  exe;
  mem_op_t  mem;
  gpr_sel_t gpr;
  pc_sel_t  pc;

  // ALU and comparator selection
  always_comb begin : exe_gen
    exe = EXE_ADD;
    if (fields_i.opcode == REG_OP || fields_i.opcode == IMM_OP) begin
      case (fields_i.funct3)
        // ADDI has no SUB form, bit 30 is immediate there
        F3_ADD:  exe = (fields_i.opcode == REG_OP && fields_i.alt) ? EXE_SUB : EXE_ADD;
        F3_SLL:  exe = EXE_SLL;
        F3_SLT:  exe = EXE_SLT;
        F3_SLTU: exe = EXE_SLTU;
        F3_XOR:  exe = EXE_XOR;
        F3_SR:   exe = fields_i.alt ? EXE_SRA : EXE_SRL;
        F3_OR:   exe = EXE_OR;
        F3_AND:  exe = EXE_AND;
        default: exe = EXE_ADD;
      endcase
    end else if (fields_i.opcode == BRANCH_OP) begin
      case (fields_i.funct3)
        F3_BEQ:  exe = EXE_EQ;
        F3_BNE:  exe = EXE_NE;
        F3_BLT:  exe = EXE_SLT;
        F3_BGE:  exe = EXE_GE;
        F3_BLTU: exe = EXE_SLTU;
        F3_BGEU: exe = EXE_GEU;
        // 010 and 011 are reserved encodings
        default: exe = EXE_ADD;
      endcase
    end
    // Address calc, AUIPC, LUI and jumps all add
  end

  // Access size and sign for the memory stage
  always_comb begin : mem_gen
    mem = MEM_IDLE;
    if (fields_i.opcode == LOAD_OP) begin
      case (fields_i.funct3)
        F3_B:    mem = MEM_RB;
        F3_H:    mem = MEM_RH;
        F3_BU:   mem = MEM_RBU;
        F3_HU:   mem = MEM_RHU;
        default: mem = MEM_RW;
      endcase
    end else if (fields_i.opcode == STORE_OP) begin
      case (fields_i.funct3)
        F3_B:    mem = MEM_WB;
        F3_H:    mem = MEM_WH;
        default: mem = MEM_WW;
      endcase
    end
  end

  // Writeback source, idle keeps unsupported words out of the GPRs
  always_comb begin : gpr_gen
    case (fields_i.opcode)
      LOAD_OP:                                  gpr = GPR_MEM;
      IMM_OP, REG_OP, AUIPC_OP, LUI_OP:         gpr = GPR_ALU;
      JAL_OP, JALR_OP:                          gpr = GPR_PRGMC;
      default:                                  gpr = GPR_IDLE;
    endcase
  end

  // Next PC rule, sequential by default
  always_comb begin : pc_gen
    case (fields_i.opcode)
      JALR_OP:   pc = PC_SET;
      JAL_OP:    pc = PC_ADD;
      BRANCH_OP: pc = PC_COND;
      default:   pc = PC_INC;
    endcase
  end

  assign ctrl_o.exe = exe;
  assign ctrl_o.mem = mem;
  assign ctrl_o.gpr = gpr;
  assign ctrl_o.pc  = pc;

endmodule

// ==== design/id_field_decode.sv ====
// Instruction field extraction and masking, immediate expansion, ready/valid generation
`timescale 1ns/1ps

module id_field_decode (
  input  logic                      rstn_i,
  input  riscv_isa_pkg::instr_t     instr_i,
  input  logic                      exe_ready_i,
  input  logic                      rs1_dirty_i,
  input  logic                      rs2_dirty_i,
  output riscv_isa_pkg::id_fields_t fields_o,
  output logic                      ready_o,
  output logic                      valid_o
);

  import riscv_isa_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic       supported;
  logic       srcs_clean;
  data_t      imm_i;
  data_t      imm_iu;
  data_t      imm_s;
  data_t      imm_b;
  data_t      imm_u;
  data_t      imm_j;
  id_fields_t fields;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Immediate formats, sign always from bit 31
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  // Shift amount form, no sign
  assign imm_iu = {{(XLEN-12){1'b0}}, instr_i[31:20]};
  assign imm_s  = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b  = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                   instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_j  = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                   instr_i[20], instr_i[30:21], 1'b0};

  // Raw fields first, then per format masking
  always_comb begin : field_select
    supported     = 1'b1;
    fields.opcode = opcode;
    fields.funct3 = funct3;
    fields.alt    = instr_i[30];
    fields.rs1    = instr_i[19:15];
    fields.rs2    = instr_i[24:20];
    fields.rd     = instr_i[11:7];
    fields.imm    = '0;
    case (opcode)
      LOAD_OP, JALR_OP: begin
        fields.rs2 = '0;
        fields.imm = imm_i;
      end
      IMM_OP: begin
        fields.rs2 = '0;
        // SLLI and SRLI/SRAI keep funct7 bits in the upper field
        fields.imm = (funct3 == F3_SLL || funct3 == F3_SR) ? imm_iu : imm_i;
      end
      STORE_OP: begin
        fields.rd  = '0;
        fields.imm = imm_s;
      end
      BRANCH_OP: begin
        fields.rd  = '0;
        fields.imm = imm_b;
      end
      REG_OP: begin
        fields.imm = '0;
      end
      AUIPC_OP, LUI_OP: begin
        fields.rs1 = '0;
        fields.rs2 = '0;
        fields.imm = imm_u;
      end
      JAL_OP: begin
        fields.rs1 = '0;
        fields.rs2 = '0;
        fields.imm = imm_j;
      end
      default: begin
        // RV64 W forms, SYSTEM and junk all land here
        supported     = 1'b0;
        fields        = '0;
        fields.opcode = OP_NONE;
      end
    endcase
    // Reset forces the unsupported value downstream
    if (!rstn_i) begin
      fields        = '0;
      fields.opcode = OP_NONE;
    end
  end

  assign fields_o = fields;

  // Unused sources are x0 after masking, and x0 is never dirty
  assign srcs_clean = !rs1_dirty_i && !rs2_dirty_i;

  always_comb begin : handshake
    if (!rstn_i) begin
      ready_o = 1'b0;
      valid_o = 1'b0;
    end else if (supported) begin
      ready_o = srcs_clean && exe_ready_i;
      valid_o = srcs_clean;
    end else begin
      // Drop the word and let fetch move on
      ready_o = 1'b1;
      valid_o = 1'b0;
    end
  end

endmodule

// ==== design/core_ctrl_pkg.sv ====
// Pipeline control code types and values, control and operand structs
package core_ctrl_pkg;

  // Code widths for each downstream consumer
  localparam int EXE_OP_W  = 5;
  localparam int MEM_OP_W  = 4;
  localparam int GPR_SEL_W = 2;
  localparam int PC_SEL_W  = 2;

  typedef logic [EXE_OP_W-1:0]  exe_op_t;
  typedef logic [MEM_OP_W-1:0]  mem_op_t;
  typedef logic [GPR_SEL_W-1:0] gpr_sel_t;
  typedef logic [PC_SEL_W-1:0]  pc_sel_t;

  // ALU operations
  localparam exe_op_t EXE_ADD  = 5'd0;
  localparam exe_op_t EXE_SUB  = 5'd1;
  localparam exe_op_t EXE_SLL  = 5'd2;
  localparam exe_op_t EXE_SLT  = 5'd3;
  localparam exe_op_t EXE_SLTU = 5'd4;
  localparam exe_op_t EXE_XOR  = 5'd5;
  localparam exe_op_t EXE_SRL  = 5'd6;
  localparam exe_op_t EXE_SRA  = 5'd7;
  localparam exe_op_t EXE_OR   = 5'd8;
  localparam exe_op_t EXE_AND  = 5'd9;
  // Branch comparisons, signed forms reuse SLT
  localparam exe_op_t EXE_EQ   = 5'd10;
  localparam exe_op_t EXE_NE   = 5'd11;
  localparam exe_op_t EXE_GE   = 5'd12;
  localparam exe_op_t EXE_GEU  = 5'd13;

  // Memory stage accesses
  localparam mem_op_t MEM_IDLE = 4'd0;
  localparam mem_op_t MEM_RB   = 4'd1;
  localparam mem_op_t MEM_RH   = 4'd2;
  localparam mem_op_t MEM_RW   = 4'd3;
  localparam mem_op_t MEM_RBU  = 4'd4;
  localparam mem_op_t MEM_RHU  = 4'd5;
  localparam mem_op_t MEM_WB   = 4'd6;
  localparam mem_op_t MEM_WH   = 4'd7;
  localparam mem_op_t MEM_WW   = 4'd8;

  // Writeback source for rd
  localparam gpr_sel_t GPR_IDLE  = 2'd0;
  localparam gpr_sel_t GPR_MEM   = 2'd1;
  localparam gpr_sel_t GPR_ALU   = 2'd2;
  // Return address, pc plus 4
  localparam gpr_sel_t GPR_PRGMC = 2'd3;

  // Next PC rule
  localparam pc_sel_t PC_INC  = 2'd0;
  localparam pc_sel_t PC_SET  = 2'd1;
  localparam pc_sel_t PC_ADD  = 2'd2;
  localparam pc_sel_t PC_COND = 2'd3;

  // Control bundle for the later stages
  typedef struct packed {
    exe_op_t  exe;
    mem_op_t  mem;
    gpr_sel_t gpr;
    pc_sel_t  pc;
  } id_ctrl_t;

  // Operand bundle, op3 carries store data, branch offset or link pc
  typedef struct packed {
    riscv_isa_pkg::data_t op1;
    riscv_isa_pkg::data_t op2;
    riscv_isa_pkg::data_t op3;
  } id_operands_t;

endpackage

// ==== design/riscv_isa_pkg.sv ====
// RV32I encoding constants, width types and the decoded instruction fields struct
package riscv_isa_pkg;

  // Base widths of the RV32I word and its fields
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int OPCODE_W  = 7;
  localparam int FUNCT3_W  = 3;

  // Width types that carry a meaning in the datapath
  typedef logic [XLEN-1:0]      data_t;
  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [XLEN-1:0]      instr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [FUNCT3_W-1:0]  funct3_t;

  // Major opcodes, instruction bits 6:0
  localparam opcode_t LOAD_OP   = 7'b0000011;
  localparam opcode_t IMM_OP    = 7'b0010011;
  localparam opcode_t AUIPC_OP  = 7'b0010111;
  localparam opcode_t STORE_OP  = 7'b0100011;
  localparam opcode_t REG_OP    = 7'b0110011;
  localparam opcode_t LUI_OP    = 7'b0110111;
  localparam opcode_t BRANCH_OP = 7'b1100011;
  localparam opcode_t JALR_OP   = 7'b1100111;
  localparam opcode_t JAL_OP    = 7'b1101111;
  // Marks an unsupported or reset instruction
  localparam opcode_t OP_NONE   = 7'b0000000;

  // ALU funct3 for REG and IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  // SRL or SRA, told apart by bit 30
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch comparisons
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Load and store access sizes, word is the fallback
  localparam funct3_t F3_B    = 3'b000;
  localparam funct3_t F3_H    = 3'b001;
  localparam funct3_t F3_BU   = 3'b100;
  localparam funct3_t F3_HU   = 3'b101;

  // Instruction fields after masking and immediate expansion
  typedef struct packed {
    opcode_t  opcode;
    funct3_t  funct3;
    logic     alt;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    data_t    imm;
  } id_fields_t;

endpackage
